// File: Makefile
TOP := tb_l2_cache_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_l2_cache_ctrl.sv
/*
 * L2 cache controller testbench
 * directed tests against models of the tag, line and dirty arrays,
 * main memory and the L1 completion handshake
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module tb_l2_cache_ctrl;

    import l2_pkg::*;

    typedef logic [`L2_TAG_LSB-`L2_INDEX_LSB-1:0] index_t;

    localparam int          NUM_TESTS  = 5;
    localparam int          MAX_CYCLES = 16 + 400 * NUM_TESTS;
    localparam int unsigned SEED       = 32'h1c01_91db;

    logic       clk_tmp = 1'b0;
    logic       arst_n;
    logic [2:0] plru;
    logic       req;
    logic       rw;
    addr_t      addr;
    word_t      wd;
    logic       l1_complete = 1'b0;
    logic       busy, rdy, miss_stall, l1_wd_en;
    word_t      l1_wd;
    tag_vec_t   tag_rd = '0;
    line_vec_t  line_rd = '0;
    way_mask_t  dirty_rd = '0;
    logic       l2_complete = 1'b0;
    way_mask_t  way_we;
    tag_entry_t tag_wd;
    line_t      line_wd;
    logic       dirty_wd;
    logic       mem_complete = 1'b0;
    line_t      mem_rd = '0;
    logic       mem_en, mem_rw;
    mem_addr_t  mem_addr;
    line_t      mem_wd;

    // array and memory models, empty until written
    tag_vec_t   tag_arr   [index_t];
    line_vec_t  line_arr  [index_t];
    way_mask_t  dirty_arr [index_t];
    line_t      mem_arr   [mem_addr_t];

    // what the models saw last
    int         wr_cnt = 0;
    way_mask_t  last_we = '0;
    tag_entry_t last_tag = '0;
    line_t      last_line = '0;
    logic       last_dirty = 1'b0;
    int         rd_cnt = 0, wb_cnt = 0, op_cnt = 0, last_rd_op = 0, last_wb_op = 0;
    mem_addr_t  last_rd_addr = '0, last_wb_addr = '0;
    line_t      last_wb_line = '0;
    logic [2:0] mem_wait = '0;
    int         stall_cycles = 0;
    int         cycle_cnt = 0;
    string      test_name = "";
    int         test_errs = 0, err_total = 0, tests_failed = 0, tests_run = 0;

    l2_cache_ctrl u_l2_cache_ctrl (
        .clk_tmp      (clk_tmp),
        .arst_n       (arst_n),
        .plru         (plru),
        .req          (req),
        .rw           (rw),
        .addr         (addr),
        .wd           (wd),
        .l1_complete  (l1_complete),
        .busy         (busy),
        .rdy          (rdy),
        .miss_stall   (miss_stall),
        .l1_wd_en     (l1_wd_en),
        .l1_wd        (l1_wd),
        .tag_rd       (tag_rd),
        .line_rd      (line_rd),
        .dirty_rd     (dirty_rd),
        .l2_complete  (l2_complete),
        .way_we       (way_we),
        .tag_wd       (tag_wd),
        .line_wd      (line_wd),
        .dirty_wd     (dirty_wd),
        .mem_complete (mem_complete),
        .mem_rd       (mem_rd),
        .mem_en       (mem_en),
        .mem_rw       (mem_rw),
        .mem_addr     (mem_addr),
        .mem_wd       (mem_wd)
    );

    always #10 clk_tmp = ~clk_tmp;

    function automatic index_t index_of(input addr_t a);
        return a[`L2_TAG_LSB-1:`L2_INDEX_LSB];
    endfunction

    function automatic mem_addr_t line_addr_of(input addr_t a);
        return a[`L2_ADDR_W-1:`L2_INDEX_LSB];
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input word_off_t o);
        return {t, i, o, {`L2_OFF_LSB{1'b0}}};
    endfunction

    // word n of a line sits at bits 128n+127 down to 128n
    function automatic word_t word_of(input line_t l, input word_off_t off);
        return l[`L2_WORD_W*int'(off) +: `L2_WORD_W];
    endfunction

    function automatic line_t put_word(input line_t l, input word_off_t off, input word_t w);
        line_t r;
        r = l;
        r[`L2_WORD_W*int'(off) +: `L2_WORD_W] = w;
        return r;
    endfunction

    function automatic tag_vec_t tags_at(input index_t idx);
        if (tag_arr.exists(idx)) return tag_arr[idx];
        return '0;
    endfunction

    function automatic line_vec_t lines_at(input index_t idx);
        if (line_arr.exists(idx)) return line_arr[idx];
        return '0;
    endfunction

    function automatic way_mask_t dirty_at(input index_t idx);
        if (dirty_arr.exists(idx)) return dirty_arr[idx];
        return '0;
    endfunction

    function automatic word_t random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic line_t random_line();
        line_t l;
        l = '0;
        for (int i = 0; i < `L2_LINE_W / 32; i++) begin
            l = {l[`L2_LINE_W-33:0], $urandom};
        end
        return l;
    endfunction

    // arrays read combinationally for the index, settled well before the next edge
    always @(negedge clk_tmp) begin
        tag_rd   <= tags_at(index_of(addr));
        line_rd  <= lines_at(index_of(addr));
        dirty_rd <= dirty_at(index_of(addr));
    end

    task automatic write_arrays();
        index_t    idx;
        tag_vec_t  tv;
        line_vec_t lv;
        way_mask_t dv;
        idx = index_of(addr);
        tv  = tags_at(idx);
        lv  = lines_at(idx);
        dv  = dirty_at(idx);
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (way_we[w]) begin
                tv[w] = tag_wd;
                lv[w] = line_wd;
                dv[w] = dirty_wd;
            end
        end
        tag_arr[idx]   = tv;
        line_arr[idx]  = lv;
        dirty_arr[idx] = dv;
        last_we    = way_we;
        last_tag   = tag_wd;
        last_line  = line_wd;
        last_dirty = dirty_wd;
        wr_cnt++;
    endtask

    // l2_complete one cycle after way_we, write on the completing edge
    always @(posedge clk_tmp) begin
        if (l2_complete) begin
            l2_complete <= 1'b0;
            write_arrays();
        end else if (arst_n && way_we != '0) begin
            l2_complete <= 1'b1;
        end
    end

    task automatic serve_memory();
        op_cnt++;
        if (mem_rw) begin
            mem_arr[mem_addr] = mem_wd;
            wb_cnt++;
            last_wb_addr = mem_addr;
            last_wb_line = mem_wd;
            last_wb_op   = op_cnt;
        end else begin
            if (!mem_arr.exists(mem_addr)) begin
                mem_arr[mem_addr] = random_line();  // untouched lines are random
            end
            mem_rd <= mem_arr[mem_addr];
            rd_cnt++;
            last_rd_addr = mem_addr;
            last_rd_op   = op_cnt;
        end
    endtask

    // mem_complete four cycles after mem_en
    always @(posedge clk_tmp) begin
        if (mem_complete) begin
            mem_complete <= 1'b0;
            mem_wait     <= '0;
        end else if (arst_n && mem_en) begin
            if (mem_wait == 3'd3) begin
                mem_complete <= 1'b1;
                serve_memory();
            end else begin
                mem_wait <= mem_wait + 3'd1;
            end
        end
    end

    always @(posedge clk_tmp) begin
        l1_complete <= arst_n && rdy && !l1_complete;   // one cycle after rdy
    end

    always @(negedge clk_tmp) begin
        if (miss_stall) stall_cycles <= stall_cycles + 1;
    end

    always @(posedge clk_tmp) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic check(input string what, input logic [511:0] exp, input logic [511:0] act);
        assert (act === exp) else begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", test_name, msg);
            test_errs++;
            err_total++;
        end
    endtask

    task automatic set_plru(input logic [2:0] p);
        @(posedge clk_tmp);
        plru <= p;
    endtask

    // one L1 access; cycles counts edges from the one that drives req
    task automatic access(input logic is_wr, input addr_t a, input word_t w,
                          output word_t rdata, output int cycles);
        @(posedge clk_tmp);
        req    <= 1'b1;
        rw     <= is_wr;
        addr   <= a;
        wd     <= w;
        cycles = 0;
        rdata  = '0;
        do begin
            @(posedge clk_tmp);
            req <= 1'b0;
            cycles++;
            @(negedge clk_tmp);
        end while (is_wr ? busy : !rdy);
        if (!is_wr) begin
            expect_true(l1_wd_en, "l1_wd_en was low while rdy was high");
            rdata = l1_wd;
            while (busy) @(negedge clk_tmp);
        end
    endtask

    task automatic test_read_miss();
        addr_t     a;
        word_t     rdata;
        int        cycles, rd0, wb0, st0;
        tag_vec_t  tv;
        way_mask_t dv;
        begin_test("read_miss_empty");
        a   = make_addr(17'h000a5, 9'h012, 2'd2);
        rd0 = rd_cnt;
        wb0 = wb_cnt;
        st0 = stall_cycles;
        access(1'b0, a, '0, rdata, cycles);
        tv = tags_at(index_of(a));
        dv = dirty_at(index_of(a));
        check("memory reads", 512'(rd0 + 1), 512'(rd_cnt));
        check("write-backs", 512'(wb0), 512'(wb_cnt));
        check("read address", 512'(line_addr_of(a)), 512'(last_rd_addr));
        check("way 0 entry", 512'({1'b1, 17'h000a5}), 512'(tv[0]));
        check("way 0 dirty", 512'(1'b0), 512'(dv[0]));
        check("read word", 512'(word_of(mem_arr[line_addr_of(a)], 2'd2)), 512'(rdata));
        expect_true(stall_cycles != st0, "miss_stall never rose during the miss");
        expect_true(!miss_stall, "miss_stall still high after the access");
        end_test();
    endtask

    task automatic test_read_hits();
        addr_t     a;
        word_t     rdata;
        int        cycles, rd0, wb0, st0;
        line_vec_t lv;
        begin_test("read_hits");
        lv  = lines_at(9'h012);
        rd0 = rd_cnt;
        wb0 = wb_cnt;
        st0 = stall_cycles;
        for (int off = 0; off < 4; off++) begin
            a = make_addr(17'h000a5, 9'h012, word_off_t'(off));
            access(1'b0, a, '0, rdata, cycles);
            check("rdy latency", 512'(2), 512'(cycles));
            check("hit word", 512'(word_of(lv[0], word_off_t'(off))), 512'(rdata));
        end
        check("memory reads", 512'(rd0), 512'(rd_cnt));
        check("write-backs", 512'(wb0), 512'(wb_cnt));
        expect_true(stall_cycles == st0, "miss_stall rose on a hit");
        end_test();
    endtask

    task automatic test_write_hit();
        addr_t     a;
        word_t     w, rdata;
        int        cycles, wr0;
        line_vec_t lv;
        begin_test("write_hit");
        a   = make_addr(17'h000a5, 9'h012, 2'd1);
        w   = random_word();
        lv  = lines_at(9'h012);
        wr0 = wr_cnt;
        access(1'b1, a, w, rdata, cycles);
        check("array writes", 512'(wr0 + 1), 512'(wr_cnt));
        check("way mask", 512'(4'b0001), 512'(last_we));
        check("tag entry", 512'({1'b1, 17'h000a5}), 512'(last_tag));
        check("written line", 512'(put_word(lv[0], 2'd1, w)), 512'(last_line));
        check("dirty_wd", 512'(1'b1), 512'(last_dirty));
        access(1'b0, a, '0, rdata, cycles);
        check("read after write", 512'(w), 512'(rdata));
        end_test();
    endtask

    task automatic test_invalid_first();
        addr_t    a;
        word_t    rdata;
        int       cycles, wb0;
        tag_vec_t tv;
        begin_test("invalid_first");
        set_plru(3'b101);
        access(1'b0, make_addr(17'h01000, 9'h0c3, 2'd0), '0, rdata, cycles);
        access(1'b0, make_addr(17'h01001, 9'h0c3, 2'd0), '0, rdata, cycles);
        set_plru(3'b000);   // points at way 0, which is valid
        wb0 = wb_cnt;
        a   = make_addr(17'h01002, 9'h0c3, 2'd3);
        access(1'b0, a, '0, rdata, cycles);
        tv = tags_at(9'h0c3);
        check("fill mask", 512'(4'b0100), 512'(last_we));
        check("way 0 entry", 512'({1'b1, 17'h01000}), 512'(tv[0]));
        check("way 1 entry", 512'({1'b1, 17'h01001}), 512'(tv[1]));
        check("way 2 entry", 512'({1'b1, 17'h01002}), 512'(tv[2]));
        check("way 3 valid", 512'(1'b0), 512'(tv[3].valid));
        check("write-backs", 512'(wb0), 512'(wb_cnt));
        check("read word", 512'(word_of(mem_arr[line_addr_of(a)], 2'd3)), 512'(rdata));
        end_test();
    endtask

    task automatic test_dirty_evict();
        addr_t     a;
        word_t     w, rdata;
        int        cycles, rd0, wb0;
        tag_vec_t  tv;
        line_vec_t lv;
        way_mask_t dv;
        begin_test("dirty_evict");
        set_plru(3'b001);   // way 2 once the set is full
        for (int i = 0; i < `L2_WAYS; i++) begin
            access(1'b0, make_addr(tag_t'(17'h02000 + i), 9'h155, 2'd0), '0, rdata, cycles);
        end
        access(1'b1, make_addr(17'h02002, 9'h155, 2'd0), random_word(), rdata, cycles);
        lv = lines_at(9'h155);
        dv = dirty_at(9'h155);
        check("victim dirty", 512'(1'b1), 512'(dv[2]));
        rd0 = rd_cnt;
        wb0 = wb_cnt;
        a   = make_addr(17'h02abc, 9'h155, 2'd3);
        w   = random_word();
        access(1'b1, a, w, rdata, cycles);
        check("write-backs", 512'(wb0 + 1), 512'(wb_cnt));
        check("write-back address", 512'({17'h02002, 9'h155}), 512'(last_wb_addr));
        check("write-back line", 512'(lv[2]), 512'(last_wb_line));
        check("memory reads", 512'(rd0 + 1), 512'(rd_cnt));
        check("read address", 512'(line_addr_of(a)), 512'(last_rd_addr));
        expect_true(last_wb_op < last_rd_op, "the fill read came before the write-back");
        tv = tags_at(9'h155);
        lv = lines_at(9'h155);
        dv = dirty_at(9'h155);
        check("way 2 entry", 512'({1'b1, 17'h02abc}), 512'(tv[2]));
        check("way 2 line", 512'(put_word(mem_arr[line_addr_of(a)], 2'd3, w)), 512'(lv[2]));
        check("way 2 dirty", 512'(1'b1), 512'(dv[2]));
        expect_true(!busy, "busy still high after the write miss");
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n = 1'b0;
        req    = 1'b0;
        rw     = 1'b0;
        addr   = '0;
        wd     = '0;
        plru   = '0;
        repeat (16) @(posedge clk_tmp);
        arst_n <= 1'b1;
        @(posedge clk_tmp);
        test_read_miss();
        test_read_hits();
        test_write_hit();
        test_invalid_first();
        test_dirty_evict();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/l2_defines.svh
/*
 * L2 cache geometry
 * field positions of the request address, way count and bus widths
 */
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// organisation
`define L2_WAYS         4       // four-way set associative
`define L2_LINE_W       512     // one cache line
`define L2_WORD_W       128     // L1 transfer word
`define L2_TAG_W        17

// address widths
`define L2_ADDR_W       32      // request address from L1
`define L2_MEM_ADDR_W   26      // memory is addressed per line

// request address split
//   [31:15] tag
//   [14:6]  set index
//   [5:4]   word offset in line
`define L2_TAG_LSB      15
`define L2_INDEX_LSB    6
`define L2_OFF_LSB      4

`endif

// File: rtl/l2_cache_ctrl.sv
/*
 * L2 cache controller top
 * four-way write-back L2 between L1 and memory; tag, line and dirty
 * arrays sit outside and are read for the index of the request
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module l2_cache_ctrl (
    input  logic               clk_tmp,
    input  logic               arst_n,
    input  logic [2:0]         plru,
    // L1 side
    input  logic               req,
    input  logic               rw,
    input  l2_pkg::addr_t      addr,
    input  l2_pkg::word_t      wd,
    input  logic               l1_complete,
    output logic               busy,
    output logic               rdy,
    output logic               miss_stall,
    output logic               l1_wd_en,
    output l2_pkg::word_t      l1_wd,
    // array side
    input  l2_pkg::tag_vec_t   tag_rd,
    input  l2_pkg::line_vec_t  line_rd,
    input  l2_pkg::way_mask_t  dirty_rd,
    input  logic               l2_complete,
    output l2_pkg::way_mask_t  way_we,
    output l2_pkg::tag_entry_t tag_wd,
    output l2_pkg::line_t      line_wd,
    output logic               dirty_wd,
    // memory side
    input  logic               mem_complete,
    input  l2_pkg::line_t      mem_rd,
    output logic               mem_en,
    output logic               mem_rw,
    output l2_pkg::mem_addr_t  mem_addr,
    output l2_pkg::line_t      mem_wd
);

    import l2_pkg::*;

    logic      hit;
    way_idx_t  hit_way;
    line_t     hit_line;
    way_idx_t  victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    line_t     victim_line;
    word_off_t offset;
    word_t     rd_word;
    line_t     merged_line;

    assign offset = addr[`L2_INDEX_LSB-1:`L2_OFF_LSB];

    l2_tag_match u_tag_match (
        .addr     (addr),
        .tag_rd   (tag_rd),
        .line_rd  (line_rd),
        .hit      (hit),
        .hit_way  (hit_way),
        .hit_line (hit_line)
    );

    l2_victim_sel u_victim_sel (
        .tag_rd       (tag_rd),
        .line_rd      (line_rd),
        .dirty_rd     (dirty_rd),
        .plru         (plru),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    // word select and merge work on the hit line only
    l2_line_merge u_line_merge (
        .line        (hit_line),
        .offset      (offset),
        .wd          (wd),
        .rd_word     (rd_word),
        .merged_line (merged_line)
    );

    l2_ctrl_fsm u_ctrl_fsm (
        .clk_tmp      (clk_tmp),
        .arst_n       (arst_n),
        .req          (req),
        .rw           (rw),
        .addr         (addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_word      (rd_word),
        .merged_line  (merged_line),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .l1_complete  (l1_complete),
        .l2_complete  (l2_complete),
        .mem_complete (mem_complete),
        .mem_rd       (mem_rd),
        .busy         (busy),
        .rdy          (rdy),
        .miss_stall   (miss_stall),
        .l1_wd_en     (l1_wd_en),
        .l1_wd        (l1_wd),
        .way_we       (way_we),
        .tag_wd       (tag_wd),
        .line_wd      (line_wd),
        .dirty_wd     (dirty_wd),
        .mem_en       (mem_en),
        .mem_rw       (mem_rw),
        .mem_addr     (mem_addr),
        .mem_wd       (mem_wd)
    );

endmodule

`default_nettype wire

// File: rtl/l2_ctrl_fsm.sv
/*
 * L2 access state machine
 * sequences lookup, the L1 read response, write hits, dirty write-back,
 * line fill from memory and the re-lookup after a fill
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module l2_ctrl_fsm (
    input  logic               clk_tmp,
    input  logic               arst_n,
    // L1 request
    input  logic               req,
    input  logic               rw,
    input  l2_pkg::addr_t      addr,
    // datapath results, valid in LOOKUP
    input  logic               hit,
    input  l2_pkg::way_idx_t   hit_way,
    input  l2_pkg::word_t      rd_word,
    input  l2_pkg::line_t      merged_line,
    input  l2_pkg::way_idx_t   victim_way,
    input  logic               victim_dirty,
    input  l2_pkg::tag_t       victim_tag,
    input  l2_pkg::line_t      victim_line,
    // completions
    input  logic               l1_complete,
    input  logic               l2_complete,
    input  logic               mem_complete,
    input  l2_pkg::line_t      mem_rd,
    // L1 side
    output logic               busy,
    output logic               rdy,
    output logic               miss_stall,
    output logic               l1_wd_en,
    output l2_pkg::word_t      l1_wd,
    // array side
    output l2_pkg::way_mask_t  way_we,
    output l2_pkg::tag_entry_t tag_wd,
    output l2_pkg::line_t      line_wd,
    output logic               dirty_wd,
    // memory side
    output logic               mem_en,
    output logic               mem_rw,
    output l2_pkg::mem_addr_t  mem_addr,
    output l2_pkg::line_t      mem_wd
);

    import l2_pkg::*;

    l2_state_t state;
    way_idx_t  fill_way;        // victim held over write-back and fill
    tag_t      req_tag;
    logic [`L2_TAG_LSB-`L2_INDEX_LSB-1:0] req_index;

    assign req_tag   = addr[`L2_ADDR_W-1:`L2_TAG_LSB];
    assign req_index = addr[`L2_TAG_LSB-1:`L2_INDEX_LSB];

    // state and handshake flags
    always_ff @(posedge clk_tmp or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            busy       <= 1'b0;
            rdy        <= 1'b0;
            l1_wd_en   <= 1'b0;
            miss_stall <= 1'b0;
            mem_en     <= 1'b0;
            way_we     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        busy  <= 1'b1;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        miss_stall <= 1'b0;
                        if (rw) begin
                            way_we <= way_mask_t'(1) << hit_way;
                            state  <= WR_HIT;
                        end else begin
                            rdy      <= 1'b1;
                            l1_wd_en <= 1'b1;
                            state    <= RESP_L1;
                        end
                    end else begin
                        miss_stall <= 1'b1;
                        if (victim_dirty) begin
                            mem_en <= 1'b1;     // write-back goes out at once
                            state  <= WB_MEM;
                        end else begin
                            state <= RD_MEM;
                        end
                    end
                end
                RESP_L1: begin
                    if (l1_complete) begin
                        rdy      <= 1'b0;
                        l1_wd_en <= 1'b0;
                        busy     <= 1'b0;
                        state    <= IDLE;
                    end
                end
                WR_HIT: begin
                    if (l2_complete) begin
                        way_we <= '0;
                        busy   <= 1'b0;
                        state  <= IDLE;
                    end
                end
                WB_MEM: begin
                    if (mem_complete) begin
                        mem_en <= 1'b0;     // one idle cycle before the read
                        state  <= RD_MEM;
                    end
                end
                RD_MEM: begin
                    if (!mem_en) begin
                        mem_en <= 1'b1;
                    end else if (mem_complete) begin
                        mem_en <= 1'b0;
                        way_we <= way_mask_t'(1) << fill_way;
                        state  <= FILL;
                    end
                end
                FILL: begin
                    if (l2_complete) begin
                        way_we <= '0;
                        state  <= LOOKUP;   // access hits on the second pass
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers, loaded alongside the flags above
    always_ff @(posedge clk_tmp) begin
        case (state)
            LOOKUP: begin
                if (hit) begin
                    l1_wd    <= rd_word;
                    tag_wd   <= '{valid: 1'b1, tag: req_tag};
                    line_wd  <= merged_line;
                    dirty_wd <= 1'b1;
                end else begin
                    fill_way <= victim_way;
                    mem_rw   <= 1'b1;
                    mem_addr <= {victim_tag, req_index};    // victim's own line
                    mem_wd   <= victim_line;
                end
            end
            RD_MEM: begin
                if (!mem_en) begin
                    mem_rw   <= 1'b0;
                    mem_addr <= addr[`L2_ADDR_W-1:`L2_INDEX_LSB];
                end else if (mem_complete) begin
                    tag_wd   <= '{valid: 1'b1, tag: req_tag};
                    line_wd  <= mem_rd;     // fill data valid with completion
                    dirty_wd <= 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/l2_line_merge.sv
/*
 * L2 line merge
 * reads the addressed 128-bit word out of a line and builds the line
 * with that word replaced by the L1 write word
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module l2_line_merge (
    input  l2_pkg::line_t     line,
    input  l2_pkg::word_off_t offset,
    input  l2_pkg::word_t     wd,
    output l2_pkg::word_t     rd_word,
    output l2_pkg::line_t     merged_line
);

    import l2_pkg::*;

    // word n sits at bits 128n+127 down to 128n
    word_t [`L2_LINE_W/`L2_WORD_W-1:0] words;
    word_t [`L2_LINE_W/`L2_WORD_W-1:0] merged;

    assign words   = line;
    assign rd_word = words[offset];

    always_comb begin
        merged         = words;
        merged[offset] = wd;    // only the addressed word changes
    end

    assign merged_line = merged;

endmodule

`default_nettype wire

// File: rtl/l2_pkg.sv
/*
 * L2 cache controller package
 * cache data types shared by the datapath blocks and the access FSM
 */
`default_nettype none

`include "l2_defines.svh"

package l2_pkg;

    typedef logic [`L2_ADDR_W-1:0]     addr_t;
    typedef logic [`L2_WORD_W-1:0]     word_t;
    typedef logic [`L2_LINE_W-1:0]     line_t;
    typedef logic [`L2_TAG_W-1:0]      tag_t;

    // tag array entry, valid bit on top
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [$clog2(`L2_WAYS)-1:0] way_idx_t;
    typedef logic [`L2_WAYS-1:0]         way_mask_t;   // write enables, dirty bits

    // all four ways of one set, way 0 in the low slot
    typedef tag_entry_t [`L2_WAYS-1:0] tag_vec_t;
    typedef line_t [`L2_WAYS-1:0]      line_vec_t;

    typedef logic [`L2_INDEX_LSB-`L2_OFF_LSB-1:0] word_off_t;
    typedef logic [`L2_MEM_ADDR_W-1:0]            mem_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,       // arrays read for the request index
        RESP_L1,      // read word offered to L1
        WR_HIT,       // merged line written back to the hit way
        WB_MEM,       // dirty victim to memory
        RD_MEM,       // requested line from memory
        FILL          // fetched line into the victim way
    } l2_state_t;

endpackage

`default_nettype wire

// File: rtl/l2_tag_match.sv
/*
 * L2 tag match
 * compares the request tag against the four stored tags of the set
 * and selects the hit way and its line, lowest way first
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module l2_tag_match (
    input  l2_pkg::addr_t     addr,
    input  l2_pkg::tag_vec_t  tag_rd,
    input  l2_pkg::line_vec_t line_rd,
    output logic              hit,
    output l2_pkg::way_idx_t  hit_way,
    output l2_pkg::line_t     hit_line
);

    import l2_pkg::*;

    tag_t      req_tag;
    way_mask_t match;       // per-way compare result

    assign req_tag = addr[`L2_ADDR_W-1:`L2_TAG_LSB];

    // an entry only counts when it holds a valid line
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            match[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
        end
    end

    assign hit = |match;

    // walk down so that the lowest matching way is the last one taken
    always_comb begin
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // line of the selected way, way 0 when nothing matched
    always_comb begin
        case (hit_way)
            2'd0: hit_line = line_rd[0];
            2'd1: hit_line = line_rd[1];
            2'd2: hit_line = line_rd[2];
            default: hit_line = line_rd[3];
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/l2_victim_sel.sv
/*
 * L2 victim selection
 * picks the way to replace on a miss: the lowest invalid way,
 * otherwise the way pointed to by the pseudo-LRU bits
 */
`default_nettype none
`timescale 1ns/100ps

`include "l2_defines.svh"

module l2_victim_sel (
    input  l2_pkg::tag_vec_t  tag_rd,
    input  l2_pkg::line_vec_t line_rd,
    input  l2_pkg::way_mask_t dirty_rd,
    input  logic [2:0]        plru,
    output l2_pkg::way_idx_t  victim_way,
    output logic              victim_dirty,
    output l2_pkg::tag_t      victim_tag,
    output l2_pkg::line_t     victim_line
);

    import l2_pkg::*;

    way_mask_t  valid_vec;
    way_idx_t   plru_way;
    tag_entry_t victim_entry;

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            valid_vec[w] = tag_rd[w].valid;
        end
    end

    // tree pLRU: bit 0 picks the half, bit 1 or bit 2 the way in it
    assign plru_way = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};

    // empty ways first, lowest one wins
    always_comb begin
        victim_way = plru_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    assign victim_entry = tag_rd[victim_way];
    assign victim_tag   = victim_entry.tag;
    assign victim_line  = line_rd[victim_way];

    // stale dirty bit of an empty way must not cause a write-back
    assign victim_dirty = victim_entry.valid && dirty_rd[victim_way];

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/l2_pkg.sv
rtl/l2_tag_match.sv
rtl/l2_victim_sel.sv
rtl/l2_line_merge.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_ctrl.sv
bench/tb_l2_cache_ctrl.sv
